// File: source/spritePkg.sv
package spritePkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Direction codes, as read back in regStatus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		dirIdle  = 3'd0,
		dirRight = 3'd1,
		dirDown  = 3'd2,
		dirUp    = 3'd3,
		dirLeft  = 3'd4
	} moveDir;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB register map (byte addresses).
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [7:0] {
		regCtrl   = 8'h00,
		regPeriod = 8'h04,
		regPos    = 8'h08,
		regStatus = 8'h0C
	} regAddr;

	// Field positions inside the registers.
	localparam int ctrlEnableBit = 0;
	localparam int ctrlStepLsb = 4; // Four bit step size.
	localparam int posYLsb = 16; // X sits in the low half.
	localparam int statusStepsLsb = 16; // Direction sits in bits 2 to 0.

endpackage

// File: source/spriteMoveFSM.sv
`timescale 1ns/10ps

module spriteMoveFSM (
	input logic clk,
	input logic reset,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	output spritePkg::moveDir dir
);

	spritePkg::moveDir nextDir;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next direction, priority depends on the current one.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		nextDir = dir;
		case (dir)
			spritePkg::dirIdle: begin
				if (left) nextDir = spritePkg::dirLeft;
				else if (right) nextDir = spritePkg::dirRight;
				else if (up) nextDir = spritePkg::dirUp;
				else if (down) nextDir = spritePkg::dirDown;
				else nextDir = spritePkg::dirIdle;
			end
			spritePkg::dirLeft: begin
				if (right) nextDir = spritePkg::dirRight;
				else if (up) nextDir = spritePkg::dirUp;
				else if (down) nextDir = spritePkg::dirDown;
				else nextDir = spritePkg::dirLeft;
			end
			spritePkg::dirRight: begin
				if (left) nextDir = spritePkg::dirLeft;
				else if (up) nextDir = spritePkg::dirUp;
				else if (down) nextDir = spritePkg::dirDown;
				else nextDir = spritePkg::dirRight;
			end
			spritePkg::dirUp: begin
				// Up holds itself first, so a held up button wins.
				if (up) nextDir = spritePkg::dirUp;
				else if (down) nextDir = spritePkg::dirDown;
				else if (right) nextDir = spritePkg::dirRight;
				else if (left) nextDir = spritePkg::dirLeft;
				else nextDir = spritePkg::dirUp;
			end
			spritePkg::dirDown: begin
				if (up) nextDir = spritePkg::dirUp;
				else if (right) nextDir = spritePkg::dirRight;
				else if (left) nextDir = spritePkg::dirLeft;
				else nextDir = spritePkg::dirDown;
			end
			default: nextDir = spritePkg::dirIdle; // Recover from an illegal code.
		endcase
	end

	// The state register is the direction output itself.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			dir <= spritePkg::dirIdle;
		end else begin
			dir <= nextDir;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	dirLegal: assert property (
		@(posedge clk) disable iff (reset)
		dir inside {spritePkg::dirIdle, spritePkg::dirRight, spritePkg::dirDown,
			spritePkg::dirUp, spritePkg::dirLeft}
	) else $error("Illegal direction code %0d.", dir);

endmodule

// File: source/moveTimer.sv
`timescale 1ns/10ps

module moveTimer #(
	parameter int periodWidth = 16
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic [periodWidth-1:0] period,
	input logic periodWrite,
	output logic stepTick
);

	logic [periodWidth-1:0] count; // Cycles left before the next tick, 0 means reload.
	logic [periodWidth-1:0] loadValue;
	logic [periodWidth-1:0] current;

	assign loadValue = (period == '0) ? periodWidth'(1) : period; // A period of 0 runs as 1.
	assign current = (count == '0) ? loadValue : count;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			stepTick <= 1'b0;
		end else if (!enable || periodWrite) begin
			count <= '0;
			stepTick <= 1'b0;
		end else begin
			count <= current - periodWidth'(1);
			stepTick <= (current == periodWidth'(1));
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// A tick is only issued from a cycle in which the timer was enabled.
	tickNeedsEnable: assert property (
		@(posedge clk) disable iff (reset)
		$rose(stepTick) |-> $past(enable)
	) else $error("Step tick rose while the timer was disabled.");

endmodule

// File: source/positionUpdate.sv
`timescale 1ns/10ps

module positionUpdate #(
	parameter int coordWidth = 10,
	parameter int screenWidth = 640,
	parameter int screenHeight = 480
) (
	input logic clk,
	input logic reset,
	input spritePkg::moveDir dir,
	input logic stepTick,
	input logic [3:0] stepSize,
	input logic posLoad,
	input logic [15:0] loadX,
	input logic [15:0] loadY,
	output logic [coordWidth-1:0] posX,
	output logic [coordWidth-1:0] posY,
	output logic [15:0] stepCount
);

	localparam logic [coordWidth-1:0] xMax = coordWidth'(screenWidth - 1);
	localparam logic [coordWidth-1:0] yMax = coordWidth'(screenHeight - 1);

	logic [coordWidth:0] xSum; // One extra bit catches the overflow.
	logic [coordWidth:0] ySum;
	logic [coordWidth-1:0] stepX;
	logic [coordWidth-1:0] stepY;
	logic [coordWidth-1:0] loadXClamped;
	logic [coordWidth-1:0] loadYClamped;
	logic takeStep;

	assign takeStep = stepTick && (dir != spritePkg::dirIdle);
	assign xSum = {1'b0, posX} + stepSize;
	assign ySum = {1'b0, posY} + stepSize;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Saturating step
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		stepX = posX;
		stepY = posY;
		case (dir)
			spritePkg::dirRight: stepX = (xSum > xMax) ? xMax : xSum[coordWidth-1:0];
			spritePkg::dirLeft: stepX = (posX < stepSize) ? '0 : posX - stepSize;
			spritePkg::dirDown: stepY = (ySum > yMax) ? yMax : ySum[coordWidth-1:0];
			spritePkg::dirUp: stepY = (posY < stepSize) ? '0 : posY - stepSize;
			default: begin
				stepX = posX;
				stepY = posY;
			end
		endcase
	end

	assign loadXClamped = (loadX > xMax) ? xMax : loadX[coordWidth-1:0];
	assign loadYClamped = (loadY > yMax) ? yMax : loadY[coordWidth-1:0];

	// A processor load wins over a step in the same cycle.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			posX <= '0;
			posY <= '0;
			stepCount <= '0;
		end else if (posLoad) begin
			posX <= loadXClamped;
			posY <= loadYClamped;
		end else if (takeStep) begin
			posX <= stepX;
			posY <= stepY;
			stepCount <= stepCount + 16'd1; // Counts pinned steps as well.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	posInRange: assert property (
		@(posedge clk) disable iff (reset)
		(posX <= xMax) && (posY <= yMax)
	) else $error("Position %0d,%0d left the screen.", posX, posY);

endmodule

// File: source/spriteRegs.sv
`timescale 1ns/10ps

module spriteRegs #(
	parameter int coordWidth = 10,
	parameter int periodWidth = 16
) (
	input logic clk,
	input logic reset,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [7:0] pAddr,
	input logic [31:0] pWdata,
	output logic [31:0] pRdata,
	output logic pSlvErr,
	input logic [coordWidth-1:0] posX,
	input logic [coordWidth-1:0] posY,
	input logic [15:0] stepCount,
	input spritePkg::moveDir dir,
	output logic enable,
	output logic [3:0] stepSize,
	output logic [periodWidth-1:0] period,
	output logic periodWrite,
	output logic posLoad,
	output logic [15:0] loadX,
	output logic [15:0] loadY
);

	logic access;
	logic wrAccess;
	logic ctrlWrite;
	logic addrHit;

	assign access = pSel && pEnable; // APB access phase, always zero wait.
	assign wrAccess = access && pWrite;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode and read mux
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		addrHit = 1'b1;
		pRdata = '0;
		case (pAddr)
			spritePkg::regCtrl: begin
				pRdata[spritePkg::ctrlEnableBit] = enable;
				pRdata[spritePkg::ctrlStepLsb +: 4] = stepSize;
			end
			spritePkg::regPeriod: begin
				pRdata[periodWidth-1:0] = period;
			end
			spritePkg::regPos: begin
				pRdata[coordWidth-1:0] = posX;
				pRdata[spritePkg::posYLsb +: coordWidth] = posY;
			end
			spritePkg::regStatus: begin
				pRdata[2:0] = dir;
				pRdata[spritePkg::statusStepsLsb +: 16] = stepCount;
			end
			default: addrHit = 1'b0;
		endcase
	end

	// Status is read only, so writing it is an error too.
	assign pSlvErr = access && (!addrHit || (pWrite && (pAddr == spritePkg::regStatus)));

	assign ctrlWrite = wrAccess && (pAddr == spritePkg::regCtrl);
	assign periodWrite = wrAccess && (pAddr == spritePkg::regPeriod);
	assign posLoad = wrAccess && (pAddr == spritePkg::regPos);
	assign loadX = pWdata[15:0]; // Clamped in the position block.
	assign loadY = pWdata[spritePkg::posYLsb +: 16];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control and period registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			enable <= 1'b0;
			stepSize <= '0;
		end else if (ctrlWrite) begin
			enable <= pWdata[spritePkg::ctrlEnableBit];
			stepSize <= pWdata[spritePkg::ctrlStepLsb +: 4];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			period <= periodWidth'(1);
		end else if (periodWrite) begin
			period <= pWdata[periodWidth-1:0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	errOnlyInAccess: assert property (
		@(posedge clk) disable iff (reset)
		pSlvErr |-> (pSel && pEnable)
	) else $error("Slave error outside an access phase.");

endmodule

// File: source/spriteMover.sv
`timescale 1ns/10ps

module spriteMover #(
	parameter int coordWidth = 10,
	parameter int screenWidth = 640,
	parameter int screenHeight = 480,
	parameter int periodWidth = 16
) (
	input logic clk,
	input logic reset,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [7:0] pAddr,
	input logic [31:0] pWdata,
	output logic [31:0] pRdata,
	output logic pSlvErr
);

	spritePkg::moveDir dir;
	logic enable;
	logic [3:0] stepSize;
	logic [periodWidth-1:0] period;
	logic periodWrite;
	logic stepTick;
	logic posLoad;
	logic [15:0] loadX;
	logic [15:0] loadY;
	logic [coordWidth-1:0] posX;
	logic [coordWidth-1:0] posY;
	logic [15:0] stepCount;

	spriteMoveFSM spriteMoveFSM_i (
		.clk(clk),
		.reset(reset),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.dir(dir)
	);

	moveTimer #(
		.periodWidth(periodWidth)
	) moveTimer_i (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.period(period),
		.periodWrite(periodWrite),
		.stepTick(stepTick)
	);

	positionUpdate #(
		.coordWidth(coordWidth),
		.screenWidth(screenWidth),
		.screenHeight(screenHeight)
	) positionUpdate_i (
		.clk(clk),
		.reset(reset),
		.dir(dir),
		.stepTick(stepTick),
		.stepSize(stepSize),
		.posLoad(posLoad),
		.loadX(loadX),
		.loadY(loadY),
		.posX(posX),
		.posY(posY),
		.stepCount(stepCount)
	);

	spriteRegs #(
		.coordWidth(coordWidth),
		.periodWidth(periodWidth)
	) spriteRegs_i (
		.clk(clk),
		.reset(reset),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWdata(pWdata),
		.pRdata(pRdata),
		.pSlvErr(pSlvErr),
		.posX(posX),
		.posY(posY),
		.stepCount(stepCount),
		.dir(dir),
		.enable(enable),
		.stepSize(stepSize),
		.period(period),
		.periodWrite(periodWrite),
		.posLoad(posLoad),
		.loadX(loadX),
		.loadY(loadY)
	);

endmodule

// File: verif/spriteMoverTb.sv
`timescale 1ns/10ps

module spriteMoverTb;

	localparam int screenW = 640;
	localparam int screenH = 480;

	logic clk;
	logic reset;
	logic left;
	logic right;
	logic up;
	logic down;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [7:0] pAddr;
	logic [31:0] pWdata;
	logic [31:0] pRdata;
	logic pSlvErr;

	// Reference model state, as it stands after the last rising edge.
	logic [2:0] mDir;
	logic mEnable;
	logic [3:0] mStep;
	int mPeriod;
	int mElapsed;
	logic mTick;
	int mX;
	int mY;
	logic [15:0] mCount;

	int errors;
	int cycles;
	int cycleLimit;

	spriteMover #(
		.coordWidth(10),
		.screenWidth(screenW),
		.screenHeight(screenH),
		.periodWidth(16)
	) spriteMover_i (
		.clk(clk),
		.reset(reset),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWdata(pWdata),
		.pRdata(pRdata),
		.pSlvErr(pSlvErr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, the stimulus did not finish.", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic isPressed(input logic [2:0] d, input logic [3:0] btn);
		case (d)
			spritePkg::dirLeft: return btn[3];
			spritePkg::dirRight: return btn[2];
			spritePkg::dirUp: return btn[1];
			spritePkg::dirDown: return btn[0];
			default: return 1'b0;
		endcase
	endfunction

	// Each state lists its candidates from highest to lowest priority.
	function automatic logic [2:0] nextDirection(input logic [2:0] cur, input logic [3:0] btn);
		logic [11:0] order;
		logic [2:0] result;
		int i;
		result = cur;
		case (cur)
			spritePkg::dirIdle: order = {spritePkg::dirLeft, spritePkg::dirRight,
				spritePkg::dirUp, spritePkg::dirDown};
			spritePkg::dirLeft: order = {spritePkg::dirRight, spritePkg::dirUp,
				spritePkg::dirDown, spritePkg::dirLeft};
			spritePkg::dirRight: order = {spritePkg::dirLeft, spritePkg::dirUp,
				spritePkg::dirDown, spritePkg::dirRight};
			spritePkg::dirUp: order = {spritePkg::dirUp, spritePkg::dirDown,
				spritePkg::dirRight, spritePkg::dirLeft};
			default: order = {spritePkg::dirUp, spritePkg::dirRight,
				spritePkg::dirLeft, spritePkg::dirDown};
		endcase
		for (i = 0; i < 4; i++) begin
			if (isPressed(order[3*i +: 3], btn)) result = order[3*i +: 3]; // Later wins.
		end
		return result;
	endfunction

	function automatic int clampTo(input int v, input int hi);
		if (v < 0) return 0;
		if (v > hi) return hi;
		return v;
	endfunction

	function automatic logic [31:0] modelRead(input logic [7:0] addr);
		case (addr)
			spritePkg::regCtrl: return {24'd0, mStep, 3'd0, mEnable};
			spritePkg::regPeriod: return 32'(mPeriod);
			spritePkg::regPos: return {16'(mY), 16'(mX)};
			spritePkg::regStatus: return {mCount, 13'd0, mDir};
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic errExpected(input logic [7:0] addr, input logic write);
		logic mapped;
		mapped = (addr == spritePkg::regCtrl) || (addr == spritePkg::regPeriod) ||
			(addr == spritePkg::regPos) || (addr == spritePkg::regStatus);
		return !mapped || (write && addr == spritePkg::regStatus);
	endfunction

	// Advances the model over one rising edge with the inputs the DUT sampled.
	task automatic updateModel();
		logic wrAccess;
		logic tickNext;
		int elapsedNext;
		int xNext;
		int yNext;
		int s;
		wrAccess = pSel && pEnable && pWrite;
		s = int'(mStep);
		if (!mEnable || (wrAccess && pAddr == spritePkg::regPeriod)) begin
			elapsedNext = 0;
			tickNext = 1'b0;
		end else begin
			elapsedNext = mElapsed + 1;
			tickNext = elapsedNext >= ((mPeriod == 0) ? 1 : mPeriod);
			if (tickNext) elapsedNext = 0;
		end
		xNext = mX;
		yNext = mY;
		if (wrAccess && pAddr == spritePkg::regPos) begin
			xNext = clampTo(int'(pWdata[15:0]), screenW - 1);
			yNext = clampTo(int'(pWdata[31:16]), screenH - 1);
		end else if (mTick && mDir != spritePkg::dirIdle) begin
			if (mDir == spritePkg::dirRight) xNext = clampTo(mX + s, screenW - 1);
			if (mDir == spritePkg::dirLeft) xNext = clampTo(mX - s, screenW - 1);
			if (mDir == spritePkg::dirDown) yNext = clampTo(mY + s, screenH - 1);
			if (mDir == spritePkg::dirUp) yNext = clampTo(mY - s, screenH - 1);
			mCount = mCount + 16'd1;
		end
		if (wrAccess && pAddr == spritePkg::regCtrl) begin
			mEnable = pWdata[spritePkg::ctrlEnableBit];
			mStep = pWdata[spritePkg::ctrlStepLsb +: 4];
		end
		if (wrAccess && pAddr == spritePkg::regPeriod) mPeriod = int'(pWdata[15:0]);
		mDir = nextDirection(mDir, {left, right, up, down});
		mTick = tickNext;
		mElapsed = elapsedNext;
		mX = xNext;
		mY = yNext;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drivers and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic clockCycle();
		@(posedge clk);
		updateModel();
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
			input logic [31:0] fileExp, input logic [31:0] modelExp);
		assert (got === fileExp) else begin
			errors++;
			$display("ERROR at %0t: %s is %h, the stimulus file expects %h.", $time, what, got,
				fileExp);
		end
		assert (got === modelExp) else begin
			errors++;
			$display("ERROR at %0t: %s is %h, the model expects %h.", $time, what, got, modelExp);
		end
	endtask

	// For a read, value is the expected data; for a write, the data written.
	task automatic apbTransfer(input logic write, input logic [7:0] addr,
			input logic [31:0] value, input logic expErr);
		clockCycle();
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= write;
		pAddr <= addr;
		pWdata <= write ? value : 32'd0;
		clockCycle();
		pEnable <= 1'b1;
		@(negedge clk);
		if (!write) checkValue("Read data", pRdata, value, modelRead(addr));
		checkValue("Slave error", {31'd0, pSlvErr}, {31'd0, expErr},
			{31'd0, errExpected(addr, write)});
		clockCycle();
		pSel <= 1'b0;
		pEnable <= 1'b0;
		pWrite <= 1'b0;
	endtask

	task automatic holdButtons(input logic [3:0] pattern, input int count);
		clockCycle();
		{left, right, up, down} <= pattern;
		repeat (count) clockCycle();
		{left, right, up, down} <= 4'b0000;
	endtask

	// Walks the stimulus file, sums its cycles and runs it when execute is set.
	task automatic runStimulus(input logic execute, output int total);
		int fd;
		int n;
		logic [7:0] kind;
		logic [8*160-1:0] line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		total = 0;
		fd = $fopen("verif/spriteMoverStimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("The stimulus file could not be opened.");
			return;
		end
		while ($fscanf(fd, "%s", kind) == 1) begin
			if (kind == "#") begin
				n = $fgets(line, fd);
			end else if (kind == "B") begin
				n = $fscanf(fd, "%h %d", a, b);
				if (n != 2) begin
					errors++;
					$display("A button record in the stimulus file is incomplete.");
				end else begin
					total += int'(b) + 1;
					if (execute) holdButtons(a[3:0], int'(b));
				end
			end else if (kind == "W" || kind == "R") begin
				n = $fscanf(fd, "%h %h %h", a, b, c);
				if (n != 3) begin
					errors++;
					$display("A bus record in the stimulus file is incomplete.");
				end else begin
					total += 3;
					if (execute) apbTransfer(kind == "W", a[7:0], b, c[0]);
				end
			end else begin
				errors++;
				$display("The stimulus file holds a record of unknown kind.");
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int total;
		errors = 0;
		cycles = 0;
		reset = 1'b1;
		left = 1'b0;
		right = 1'b0;
		up = 1'b0;
		down = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = 8'd0;
		pWdata = 32'd0;
		mDir = spritePkg::dirIdle;
		mEnable = 1'b0;
		mStep = 4'd0;
		mPeriod = 1;
		mElapsed = 0;
		mTick = 1'b0;
		mX = 0;
		mY = 0;
		mCount = 16'd0;
		runStimulus(1'b0, total);
		cycleLimit = 2 * total + 100;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		runStimulus(1'b1, total);
		repeat (2) clockCycle();
		$display("Run complete, %0d errors counted.", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: spriteMover.f
source/spritePkg.sv
source/spriteMoveFSM.sv
source/moveTimer.sv
source/positionUpdate.sv
source/spriteRegs.sv
source/spriteMover.sv
verif/spriteMoverTb.sv

// File: Makefile
# Verilator simulation of the sprite motion controller.
VERILATOR ?= verilator
TOP ?= spriteMoverTb
FILELIST ?= spriteMover.f
OBJDIR ?= obj_dir
LOG ?= simulate.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

.PHONY: simulate clean

# The run passes only when the log holds the pass line.
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verif/spriteMoverStimulus.txt
# W addr data expErr | R addr expData expErr | B buttons cycles (addr and data in hex)
# Buttons in hex: 8 left, 4 right, 2 up, 1 down. Cycles in decimal.
R 04 00000001 0
W 08 00640032 0
R 08 00640032 0
W 08 03E807D0 0
R 08 01DF027F 0
W 04 00000004 0
R 04 00000004 0
W 00 00000030 0
R 00 00000030 0
R 10 00000000 1
W 20 FFFFFFFF 1
W 0C 12345678 1
R 0C 00000000 0
B F 1
R 0C 00000004 0
B 7 1
R 0C 00000001 0
B 3 1
R 0C 00000003 0
B E 1
R 0C 00000003 0
B D 1
R 0C 00000002 0
B C 1
R 0C 00000001 0
W 08 00C80064 0
W 00 00000031 0
B 4 12
W 00 00000030 0
R 08 00C80070 0
R 0C 00040001 0
B 2 1
W 04 00000001 0
W 00 000000F1 0
B 2 30
W 00 000000F0 0
R 08 00000070 0
R 0C 00260003 0
B 8 6
R 08 00000070 0
R 0C 00260004 0
